//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mini_mips
FILELIST  ?= mini_mips.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Everything OK" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_cpu,
    output logic rst_n
);

    initial begin
        clk_cpu = 1'b0;
        forever #(PERIOD_NS / 2) clk_cpu = ~clk_cpu;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_cpu);
        @(negedge clk_cpu);
        rst_n <= 1'b1;
    end

endmodule

//--- bench/tb_mini_mips.sv
`timescale 1ns/1ns
`include "mini_mips_cfg.svh"

module tb_mini_mips;

    localparam int XLEN             = `MINI_MIPS_XLEN;
    localparam int PERIOD_NS        = 40;
    localparam int NUM_INSTR        = 400;
    localparam int MAX_FLIGHT       = 6;
    // longest ack stall plus pipeline refill
    localparam int CYCLES_PER_INSTR = 80;
    localparam int TIMEOUT_NS       = (NUM_INSTR * CYCLES_PER_INSTR + 20) * PERIOD_NS;

    logic            clk_cpu;
    logic            rst_n;
    logic            in_cyc;
    logic            in_stb;
    logic [XLEN-1:0] in_dat;
    logic            in_ack;
    logic            res_cyc;
    logic            res_stb;
    logic [4:0]      res_dest;
    logic [XLEN-1:0] res_data;
    logic            res_ack;

    logic [31:0]     rng_state;
    logic [XLEN-1:0] model_regs [`MINI_MIPS_REG_COUNT];
    logic [31:0]     in_flight_q [$];
    int              accepted;
    int              retired;
    int              max_in_flight;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(4)) clock_gen_inst (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n)
    );

    mini_mips_top mini_mips_top_inst (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .in_cyc   (in_cyc),
        .in_stb   (in_stb),
        .in_dat   (in_dat),
        .in_ack   (in_ack),
        .res_cyc  (res_cyc),
        .res_stb  (res_stb),
        .res_dest (res_dest),
        .res_data (res_data),
        .res_ack  (res_ack)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // mostly the low eight registers, so results feed each other
    function automatic logic [4:0] pick_reg(input logic [31:0] r);
        return (r[7:5] == 3'b000) ? r[4:0] : {2'b00, r[2:0]};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] f;
        logic [31:0] g;
        logic [5:0]  opcode;
        logic [5:0]  funct;
        f = next_random();
        g = next_random();
        opcode = 6'h00;
        funct = 6'h20;
        case (g[31:28])
            4'd0:       funct = 6'h20;
            4'd1:       funct = 6'h22;
            4'd2:       funct = 6'h24;
            4'd3:       funct = 6'h25;
            4'd4:       funct = 6'h26;
            4'd5:       funct = 6'h2a;
            4'd6:       funct = 6'h00;
            4'd7:       funct = 6'h02;
            4'd8, 4'd9: opcode = 6'h08;
            4'd10:      opcode = 6'h0c;
            4'd11:      opcode = 6'h0d;
            4'd12:      opcode = 6'h0e;
            4'd13:      opcode = 6'h0f;
            // no supported opcode has its top bit set
            4'd14:      opcode = {1'b1, g[20:16]};
            // unused function codes 0x10 to 0x1f
            default:    funct = {2'b01, g[19:16]};
        endcase
        if (opcode == 6'h00) begin
            return {opcode, pick_reg(f), pick_reg(f >> 8), pick_reg(f >> 16), f[28:24], funct};
        end
        return {opcode, pick_reg(f), pick_reg(f >> 8), g[15:0]};
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        stop_with_failure($sformatf("MISMATCH at %0t ns: %s expected 0x%08h, got 0x%08h",
                                    $time, sig, expected, actual));
    endtask

    // reference behavior of one instruction, updates the model registers
    task automatic model_execute(input logic [31:0] w, output logic [4:0] dest,
                                 output logic [XLEN-1:0] value);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_z;
        a = model_regs[w[25:21]];
        b = model_regs[w[20:16]];
        imm_s = {{16{w[15]}}, w[15:0]};
        imm_z = {16'h0000, w[15:0]};
        dest = w[20:16];
        value = '0;
        case (w[31:26])
            6'h00: begin
                dest = w[15:11];
                case (w[5:0])
                    6'h20:   value = a + b;
                    6'h22:   value = a - b;
                    6'h24:   value = a & b;
                    6'h25:   value = a | b;
                    6'h26:   value = a ^ b;
                    6'h2a:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00:   value = b << w[10:6];
                    6'h02:   value = b >> w[10:6];
                    default: dest = 5'd0;
                endcase
            end
            6'h08:   value = a + imm_s;
            6'h0c:   value = a & imm_z;
            6'h0d:   value = a | imm_z;
            6'h0e:   value = a ^ imm_z;
            6'h0f:   value = {w[15:0], 16'h0000};
            default: dest = 5'd0;
        endcase
        // r0 stays zero
        if (dest != 5'd0) begin
            model_regs[dest] = value;
        end
    endtask

    task automatic check_result();
        logic [31:0]     word;
        logic [4:0]      exp_dest;
        logic [XLEN-1:0] exp_data;
        assert (in_flight_q.size() > 0)
            else stop_with_failure("result strobe with no outstanding instruction");
        word = in_flight_q.pop_front();
        model_execute(word, exp_dest, exp_data);
        assert (res_cyc) else report_mismatch("res_cyc", 32'd1, 32'(res_cyc));
        assert (res_dest == exp_dest)
            else report_mismatch("res_dest", 32'(exp_dest), 32'(res_dest));
        assert (res_data == exp_data) else report_mismatch("res_data", exp_data, res_data);
    endtask

    task automatic send_instr(input logic [31:0] word);
        int in_flight;
        in_cyc = 1'b1;
        in_stb = 1'b1;
        in_dat = word;
        @(negedge clk_cpu);
        while (!in_ack) begin
            @(negedge clk_cpu);
        end
        in_flight_q.push_back(word);
        accepted++;
        in_flight = accepted - retired;
        if (in_flight > max_in_flight) begin
            max_in_flight = in_flight;
        end
        assert (in_flight <= MAX_FLIGHT)
            else stop_with_failure($sformatf("%0d instructions in flight, limit is %0d",
                                             in_flight, MAX_FLIGHT));
    endtask

    task automatic check_idle_outputs(input string when);
        assert (in_ack === 1'b0 && res_cyc === 1'b0 && res_stb === 1'b0)
            else stop_with_failure($sformatf("handshake output active %s", when));
    endtask

    initial begin
        logic [31:0] r;
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_dat = '0;
        rng_state = 32'd57673;
        accepted = 0;
        retired = 0;
        max_in_flight = 0;
        for (int i = 0; i < `MINI_MIPS_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        do begin
            @(negedge clk_cpu);
            check_idle_outputs("during or right after reset");
        end while (rst_n !== 1'b1);
        for (int n = 0; n < NUM_INSTR; n++) begin
            send_instr(random_instr());
            r = next_random();
            // occasional idle gap on the host side
            if (r[2:0] == 3'd0) begin
                in_cyc = 1'b0;
                in_stb = 1'b0;
                repeat (int'(r[4:3]) + 1) @(negedge clk_cpu);
            end
        end
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_dat = '0;
        wait (retired == NUM_INSTR);
        repeat (10) begin
            @(negedge clk_cpu);
            assert (!res_stb) else stop_with_failure("extra result after the last instruction");
        end
        assert (max_in_flight == MAX_FLIGHT)
            else stop_with_failure("back-pressure never filled the pipeline to six instructions");
        $display("Everything OK");
        $finish;
    end

    // result side, ack after a random delay
    initial begin
        logic [31:0] ack_rng;
        int          delay;
        ack_rng = 32'd57673 ^ 32'h5bd1e995;
        res_ack = 1'b0;
        forever begin
            @(negedge clk_cpu);
            if (rst_n === 1'b1 && res_stb === 1'b1) begin
                check_result();
                ack_rng = xorshift32(ack_rng);
                // long stalls fill the whole pipeline
                if (ack_rng[3:0] >= 4'd13) begin
                    delay = 40 + int'(ack_rng[6:4]);
                end else begin
                    delay = int'(ack_rng[5:4]);
                end
                repeat (delay) begin
                    @(negedge clk_cpu);
                    assert (res_stb && res_cyc)
                        else stop_with_failure("result strobe dropped before res_ack");
                end
                res_ack = 1'b1;
                @(negedge clk_cpu);
                res_ack = 1'b0;
                retired++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stop_with_failure($sformatf("timeout with %0d of %0d instructions retired",
                                    retired, NUM_INSTR));
    end

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ns
`include "mini_mips_cfg.svh"

module exec_unit (
    input  logic                       clk_cpu,
    input  logic                       rst_n,
    input  logic                       res_ack,
    uop_wb_if.slave                    exec_q,
    output logic                       res_cyc,
    output logic                       res_stb,
    output isa_pkg::reg_idx_t          res_dest,
    output logic [`MINI_MIPS_XLEN-1:0] res_data
);

    localparam int XLEN      = `MINI_MIPS_XLEN;
    localparam int REG_COUNT = `MINI_MIPS_REG_COUNT;

    logic [XLEN-1:0] regs [REG_COUNT];
    uop_pkg::uop_t   op_q;
    logic            op_valid;
    logic            take;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;

    // no new micro-op while one is computing or a result waits
    assign take = exec_q.cyc && exec_q.stb && !exec_q.ack && !op_valid && !res_stb;

    assign rs_val = (op_q.rs == '0) ? '0 : regs[op_q.rs];
    assign rt_val = (op_q.rt == '0) ? '0 : regs[op_q.rt];
    assign op_b   = op_q.imm_sel ? op_q.imm : rt_val;

    always_comb begin
        case (op_q.alu_op)
            uop_pkg::ALU_ADD: alu_result = rs_val + op_b;
            uop_pkg::ALU_SUB: alu_result = rs_val - op_b;
            uop_pkg::ALU_AND: alu_result = rs_val & op_b;
            uop_pkg::ALU_OR:  alu_result = rs_val | op_b;
            uop_pkg::ALU_XOR: alu_result = rs_val ^ op_b;
            uop_pkg::ALU_SLT: alu_result = {{(XLEN - 1){1'b0}}, $signed(rs_val) < $signed(op_b)};
            // shifts take rt as the source
            uop_pkg::ALU_SLL: alu_result = rt_val << op_q.shamt;
            uop_pkg::ALU_SRL: alu_result = rt_val >> op_q.shamt;
            uop_pkg::ALU_LUI: alu_result = op_b << isa_pkg::IMM_W;
            default:          alu_result = '0;
        endcase
    end

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            exec_q.ack <= 1'b0;
            op_valid   <= 1'b0;
            res_cyc    <= 1'b0;
            res_stb    <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            exec_q.ack <= take;
            if (take) begin
                op_valid <= 1'b1;
            end
            if (op_valid) begin
                op_valid <= 1'b0;
                res_cyc  <= 1'b1;
                res_stb  <= 1'b1;
                // r0 keeps its zero
                if (op_q.dest != '0) begin
                    regs[op_q.dest] <= alu_result;
                end
            end else if (res_stb && res_ack) begin
                res_cyc <= 1'b0;
                res_stb <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (take) begin
            op_q <= exec_q.dat;
        end
        if (op_valid) begin
            res_dest <= op_q.dest;
            res_data <= alu_result;
        end
    end

    result_held: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        res_stb && !res_ack |=> res_stb && $stable(res_dest) && $stable(res_data));

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/1ns
`include "mini_mips_cfg.svh"

module instr_decoder (
    input  logic                       clk_cpu,
    input  logic                       rst_n,
    input  logic                       in_cyc,
    input  logic                       in_stb,
    input  logic [`MINI_MIPS_XLEN-1:0] in_dat,
    output logic                       in_ack,
    uop_wb_if.master                   decode_q
);

    localparam int XLEN     = `MINI_MIPS_XLEN;
    localparam int RS_LSB   = XLEN - isa_pkg::OPCODE_W - isa_pkg::REG_IDX_W;
    localparam int RT_LSB   = RS_LSB - isa_pkg::REG_IDX_W;
    localparam int RD_LSB   = RT_LSB - isa_pkg::REG_IDX_W;
    localparam int SHAMT_LSB = isa_pkg::FUNCT_W;

    logic [XLEN-1:0]             instr_q;
    logic                        pending;
    logic                        accept;
    isa_pkg::opcode_e            opcode;
    isa_pkg::funct_e             funct;
    logic [isa_pkg::IMM_W-1:0]   imm_field;
    logic [XLEN-1:0]             imm_sext;
    logic [XLEN-1:0]             imm_zext;
    uop_pkg::uop_t               uop_next;

    // slot is busy from in_ack until decode_q ack
    assign accept = in_cyc && in_stb && !in_ack && !pending && !decode_q.stb;

    assign opcode    = isa_pkg::opcode_e'(instr_q[XLEN-1 -: isa_pkg::OPCODE_W]);
    assign funct     = isa_pkg::funct_e'(instr_q[isa_pkg::FUNCT_W-1:0]);
    assign imm_field = instr_q[isa_pkg::IMM_W-1:0];
    assign imm_sext  = {{(XLEN - isa_pkg::IMM_W){imm_field[isa_pkg::IMM_W-1]}}, imm_field};
    assign imm_zext  = {{(XLEN - isa_pkg::IMM_W){1'b0}}, imm_field};

    always_comb begin
        uop_next.alu_op  = uop_pkg::ALU_ZERO;
        uop_next.rs      = instr_q[RS_LSB +: isa_pkg::REG_IDX_W];
        uop_next.rt      = instr_q[RT_LSB +: isa_pkg::REG_IDX_W];
        uop_next.dest    = '0;
        uop_next.imm_sel = 1'b0;
        uop_next.imm     = imm_zext;
        uop_next.shamt   = instr_q[SHAMT_LSB +: isa_pkg::SHAMT_W];
        case (opcode)
            isa_pkg::OP_RTYPE: begin
                uop_next.dest = instr_q[RD_LSB +: isa_pkg::REG_IDX_W];
                case (funct)
                    isa_pkg::FN_ADD: uop_next.alu_op = uop_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: uop_next.alu_op = uop_pkg::ALU_SUB;
                    isa_pkg::FN_AND: uop_next.alu_op = uop_pkg::ALU_AND;
                    isa_pkg::FN_OR:  uop_next.alu_op = uop_pkg::ALU_OR;
                    isa_pkg::FN_XOR: uop_next.alu_op = uop_pkg::ALU_XOR;
                    isa_pkg::FN_SLT: uop_next.alu_op = uop_pkg::ALU_SLT;
                    isa_pkg::FN_SLL: uop_next.alu_op = uop_pkg::ALU_SLL;
                    isa_pkg::FN_SRL: uop_next.alu_op = uop_pkg::ALU_SRL;
                    // unknown funct becomes zero to r0
                    default:         uop_next.dest   = '0;
                endcase
            end
            isa_pkg::OP_ADDI: begin
                uop_next.alu_op  = uop_pkg::ALU_ADD;
                uop_next.imm_sel = 1'b1;
                uop_next.imm     = imm_sext;
                uop_next.dest    = uop_next.rt;
            end
            isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
                uop_next.alu_op  = (opcode == isa_pkg::OP_ANDI) ? uop_pkg::ALU_AND :
                                   (opcode == isa_pkg::OP_ORI)  ? uop_pkg::ALU_OR :
                                                                  uop_pkg::ALU_XOR;
                uop_next.imm_sel = 1'b1;
                uop_next.dest    = uop_next.rt;
            end
            isa_pkg::OP_LUI: begin
                uop_next.alu_op  = uop_pkg::ALU_LUI;
                uop_next.imm_sel = 1'b1;
                uop_next.dest    = uop_next.rt;
            end
            default: uop_next.alu_op = uop_pkg::ALU_ZERO;
        endcase
    end

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            in_ack       <= 1'b0;
            pending      <= 1'b0;
            decode_q.cyc <= 1'b0;
            decode_q.stb <= 1'b0;
        end else begin
            in_ack <= accept;
            if (accept) begin
                pending <= 1'b1;
            end else if (pending) begin
                pending      <= 1'b0;
                decode_q.cyc <= 1'b1;
                decode_q.stb <= 1'b1;
            end else if (decode_q.stb && decode_q.ack) begin
                decode_q.cyc <= 1'b0;
                decode_q.stb <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (accept) begin
            instr_q <= in_dat;
        end
        if (pending) begin
            decode_q.dat <= uop_next;
        end
    end

    // an offered micro-op is held until the queue takes it
    hold_until_ack: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        decode_q.stb && !decode_q.ack |=> decode_q.stb && $stable(decode_q.dat));

endmodule

//--- hw/isa_pkg.sv
package isa_pkg;

    // instruction field widths
    localparam int OPCODE_W  = 6;
    localparam int FUNCT_W   = 6;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;
    localparam int IMM_W     = 16;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // supported primary opcodes
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f
    } opcode_e;

    // function codes under OP_RTYPE
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funct_e;

endpackage

//--- hw/mini_mips_top.sv
`timescale 1ns/1ns
`include "mini_mips_cfg.svh"

module mini_mips_top (
    input  logic                       clk_cpu,
    input  logic                       rst_n,
    input  logic                       in_cyc,
    input  logic                       in_stb,
    input  logic [`MINI_MIPS_XLEN-1:0] in_dat,
    output logic                       in_ack,
    output logic                       res_cyc,
    output logic                       res_stb,
    output isa_pkg::reg_idx_t          res_dest,
    output logic [`MINI_MIPS_XLEN-1:0] res_data,
    input  logic                       res_ack
);

    uop_wb_if decode_q ();
    uop_wb_if exec_q ();

    instr_decoder instr_decoder_inst (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .in_cyc   (in_cyc),
        .in_stb   (in_stb),
        .in_dat   (in_dat),
        .in_ack   (in_ack),
        .decode_q (decode_q.master)
    );

    uop_queue uop_queue_inst (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .decode_q (decode_q.slave),
        .exec_q   (exec_q.master)
    );

    exec_unit exec_unit_inst (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .res_ack  (res_ack),
        .exec_q   (exec_q.slave),
        .res_cyc  (res_cyc),
        .res_stb  (res_stb),
        .res_dest (res_dest),
        .res_data (res_data)
    );

endmodule

//--- hw/uop_pkg.sv
`include "mini_mips_cfg.svh"

package uop_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_ZERO
    } alu_op_e;

    // one decoded instruction as seen by execute
    typedef struct packed {
        alu_op_e                      alu_op;
        isa_pkg::reg_idx_t            rs;
        isa_pkg::reg_idx_t            rt;
        isa_pkg::reg_idx_t            dest;
        logic                         imm_sel;
        logic [`MINI_MIPS_XLEN-1:0]   imm;
        logic [isa_pkg::SHAMT_W-1:0]  shamt;
    } uop_t;

endpackage

//--- hw/uop_queue.sv
`timescale 1ns/1ns
`include "mini_mips_cfg.svh"

module uop_queue (
    input  logic     clk_cpu,
    input  logic     rst_n,
    uop_wb_if.slave  decode_q,
    uop_wb_if.master exec_q
);

    localparam int DEPTH = `MINI_MIPS_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_pkg::uop_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign push = decode_q.cyc && decode_q.stb && !decode_q.ack && !full;
    assign pop  = exec_q.stb && exec_q.ack;

    // head is offered whenever something is held
    assign exec_q.cyc = (count != '0);
    assign exec_q.stb = (count != '0);
    assign exec_q.dat = mem[rd_ptr];

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            decode_q.ack <= 1'b0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
        end else begin
            decode_q.ack <= push;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (push) begin
            mem[wr_ptr] <= decode_q.dat;
        end
    end

    count_in_range: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        count <= CNT_W'(DEPTH));

    // a full queue must not acknowledge the decoder
    no_ack_when_full: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        full |=> !decode_q.ack);

endmodule

//--- hw/uop_wb_if.sv
`timescale 1ns/1ns

// wishbone classic link, one micro-op per transfer
interface uop_wb_if;

    logic          cyc;
    logic          stb;
    uop_pkg::uop_t dat;
    logic          ack;

    modport master (
        output cyc,
        output stb,
        output dat,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  dat,
        output ack
    );

endinterface

//--- include/mini_mips_cfg.svh
`ifndef MINI_MIPS_CFG_SVH
`define MINI_MIPS_CFG_SVH

// data path and instruction width
`define MINI_MIPS_XLEN 32

// architectural registers, r0 included
`define MINI_MIPS_REG_COUNT 32

// entries between decode and execute
`define MINI_MIPS_QUEUE_DEPTH 4

`endif

//--- mini_mips.f
+incdir+include
hw/isa_pkg.sv
hw/uop_pkg.sv
hw/uop_wb_if.sv
hw/instr_decoder.sv
hw/uop_queue.sv
hw/exec_unit.sv
hw/mini_mips_top.sv
bench/tb_clock_gen.sv
bench/tb_mini_mips.sv
